/* design/memory_game_defines.svh */
// Memory game constants
`ifndef MEMORY_GAME_DEFINES_SVH
`define MEMORY_GAME_DEFINES_SVH

// board layout is three rows of six cards, one switch per card
`define MG_NUM_CARDS 18

// one decimal digit on a seven-segment display
`define MG_DIGIT_WIDTH 4

// segments a..g, active low
`define MG_SEGMENT_WIDTH 7

// clock cycles per timer second (50 MHz board clock)
`define MG_TICKS_PER_SECOND 50000000

// round timer reload value, 60 in BCD
`define MG_TIMER_START_TENS 6
`define MG_TIMER_START_ONES 0

`endif

/* design/memory_game_pkg.sv */
// Memory game types and pair table
`include "memory_game_defines.svh"

package memory_game_pkg;

	typedef logic [`MG_NUM_CARDS-1:0] card_set_t;       // one bit per card
	typedef logic [$clog2(`MG_NUM_CARDS)-1:0] card_index_t;
	typedef logic [`MG_DIGIT_WIDTH-1:0] bcd_digit_t;
	typedef logic [`MG_SEGMENT_WIDTH-1:0] segments_t;  // active low
	typedef logic [0:0] player_t;

	localparam player_t player_one = 1'b0;
	localparam player_t player_two = 1'b1;

	// press/release steps through the three phases
	typedef enum logic [2:0] {
		first_pick,
		first_hold,
		second_pick,
		second_hold,
		judge,
		judge_hold
	} phase_t;

	localparam int pair_count = `MG_NUM_CARDS / 2;

	// partner cards, entry i of each table forms one pair
	localparam card_index_t pair_hi [pair_count] = '{5'd17, 5'd16, 5'd15, 5'd14, 5'd13,
		5'd12, 5'd9, 5'd8, 5'd6};
	localparam card_index_t pair_lo [pair_count] = '{5'd10, 5'd0, 5'd4, 5'd3, 5'd2,
		5'd11, 5'd7, 5'd5, 5'd1};

	// true when any pair has one card in each set, either order
	function automatic logic pair_match(card_set_t first_set, card_set_t second_set);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < pair_count; i++)
		begin
			hit |= first_set[pair_hi[i]] & second_set[pair_lo[i]];
			hit |= first_set[pair_lo[i]] & second_set[pair_hi[i]];
		end
		return hit;
	endfunction

endpackage

/* design/turn_control.sv */
// Button-driven phase FSM
module turn_control
(
	input  logic clock,
	input  logic reset_n,
	input  logic go_n,         // push button, low when pressed
	output logic first_phase,
	output logic second_phase,
	output logic judge_phase,
	output logic pick_first,   // one-cycle strobes on release
	output logic pick_second,
	output logic judge_now
);

	memory_game_pkg::phase_t state;
	memory_game_pkg::phase_t next_state;
	logic pressed;

	assign pressed = ~go_n;

	// pick states wait for a press, hold states wait for the release
	always_comb
	begin
		case (state)
			memory_game_pkg::first_pick:  next_state = pressed ? memory_game_pkg::first_hold
				: memory_game_pkg::first_pick;
			memory_game_pkg::first_hold:  next_state = pressed ? memory_game_pkg::first_hold
				: memory_game_pkg::second_pick;
			memory_game_pkg::second_pick: next_state = pressed ? memory_game_pkg::second_hold
				: memory_game_pkg::second_pick;
			memory_game_pkg::second_hold: next_state = pressed ? memory_game_pkg::second_hold
				: memory_game_pkg::judge;
			memory_game_pkg::judge:       next_state = pressed ? memory_game_pkg::judge_hold
				: memory_game_pkg::judge;
			memory_game_pkg::judge_hold:  next_state = pressed ? memory_game_pkg::judge_hold
				: memory_game_pkg::first_pick;
			default:                      next_state = memory_game_pkg::first_pick;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			state       <= memory_game_pkg::first_pick;
			pick_first  <= 1'b0;
			pick_second <= 1'b0;
			judge_now   <= 1'b0;
		end
		else
		begin
			state       <= next_state;
			pick_first  <= (state == memory_game_pkg::first_hold) && !pressed;  // release
			pick_second <= (state == memory_game_pkg::second_hold) && !pressed;
			judge_now   <= (state == memory_game_pkg::judge_hold) && !pressed;
		end
	end

	// lights cover both the pick and the hold state
	assign first_phase  = (state == memory_game_pkg::first_pick)
		|| (state == memory_game_pkg::first_hold);
	assign second_phase = (state == memory_game_pkg::second_pick)
		|| (state == memory_game_pkg::second_hold);
	assign judge_phase  = (state == memory_game_pkg::judge)
		|| (state == memory_game_pkg::judge_hold);

endmodule

/* design/pair_checker.sv */
// Pick capture and pair judge
module pair_checker
(
	input  logic                       clock,
	input  logic                       reset_n,
	input  memory_game_pkg::card_set_t cards,        // switch positions
	input  logic                       pick_first,
	input  logic                       pick_second,
	input  logic                       judge_now,
	output logic                       match,        // one-cycle pulse
	output memory_game_pkg::player_t   turn
);

	memory_game_pkg::card_set_t first_card;
	memory_game_pkg::card_set_t second_card;
	logic both_picked;
	logic hit;

	// an empty pick makes the judge step a no-op
	assign both_picked = (first_card != '0) && (second_card != '0);
	assign hit         = memory_game_pkg::pair_match(first_card, second_card);

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			first_card  <= '0;
			second_card <= '0;
		end
		else
		begin
			if (pick_first)
				first_card <= cards;   // latched on release of first pick
			if (pick_second)
				second_card <= cards;
		end
	end

	// verdict registered one cycle after the judge strobe
	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			match <= 1'b0;
			turn  <= memory_game_pkg::player_one;
		end
		else
		begin
			match <= 1'b0;  // pulse only
			if (judge_now && both_picked)
			begin
				if (hit)
					match <= 1'b1;   // scorer keeps the turn
				else
					turn <= ~turn;   // miss, hand over
			end
		end
	end

endmodule

/* design/score_keeper.sv */
// Per-player BCD scores
module score_keeper
(
	input  logic                        clock,
	input  logic                        reset_n,
	input  logic                        match,
	input  memory_game_pkg::player_t    turn,
	output memory_game_pkg::bcd_digit_t score_p1,
	output memory_game_pkg::bcd_digit_t score_p2
);

	memory_game_pkg::bcd_digit_t p1_next;
	memory_game_pkg::bcd_digit_t p2_next;

	// modulo-ten increment
	function automatic memory_game_pkg::bcd_digit_t bump(memory_game_pkg::bcd_digit_t value);
		if (value >= 4'd9)
			return '0;
		return value + 4'd1;
	endfunction

	assign p1_next = bump(score_p1);
	assign p2_next = bump(score_p2);

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			score_p1 <= '0;
			score_p2 <= '0;
		end
		else if (match)
		begin
			if (turn == memory_game_pkg::player_one)
				score_p1 <= p1_next;
			if (turn == memory_game_pkg::player_two)
				score_p2 <= p2_next;
		end
	end

endmodule

/* design/round_timer.sv */
// Seconds countdown timer
`include "memory_game_defines.svh"

module round_timer
(
	input  logic                        clock,
	input  logic                        reset_n,
	output memory_game_pkg::bcd_digit_t sec_ones,
	output memory_game_pkg::bcd_digit_t sec_tens
);

	localparam int prescale_width = $clog2(`MG_TICKS_PER_SECOND + 1);
	localparam logic [prescale_width-1:0] prescale_load = prescale_width'(`MG_TICKS_PER_SECOND - 1);

	logic [prescale_width-1:0] prescale;
	logic tick;

	assign tick = (prescale == '0);  // one cycle per second

	always_ff @(posedge clock)
	begin
		if (!reset_n)
			prescale <= prescale_load;
		else if (tick)
			prescale <= prescale_load;
		else
			prescale <= prescale - 1'b1;
	end

	// two-digit BCD countdown, 00 wraps to the start value
	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			sec_tens <= memory_game_pkg::bcd_digit_t'(`MG_TIMER_START_TENS);
			sec_ones <= memory_game_pkg::bcd_digit_t'(`MG_TIMER_START_ONES);
		end
		else if (tick)
		begin
			if (sec_ones != '0)
				sec_ones <= sec_ones - 4'd1;
			else if (sec_tens != '0)
			begin
				sec_ones <= 4'd9;          // borrow from tens
				sec_tens <= sec_tens - 4'd1;
			end
			else
			begin
				sec_tens <= memory_game_pkg::bcd_digit_t'(`MG_TIMER_START_TENS);
				sec_ones <= memory_game_pkg::bcd_digit_t'(`MG_TIMER_START_ONES);
			end
		end
	end

endmodule

/* design/seven_seg_decoder.sv */
// Hex to seven-segment decoder
module seven_seg_decoder
(
	input  memory_game_pkg::bcd_digit_t digit,
	output memory_game_pkg::segments_t  segments  // gfedcba, low lights
);

	always_comb
	begin
		case (digit)
			4'h0: segments = 7'b1000000;
			4'h1: segments = 7'b1111001;
			4'h2: segments = 7'b0100100;
			4'h3: segments = 7'b0110000;
			4'h4: segments = 7'b0011001;
			4'h5: segments = 7'b0010010;
			4'h6: segments = 7'b0000010;
			4'h7: segments = 7'b1111000;
			4'h8: segments = 7'b0000000;
			4'h9: segments = 7'b0011000;
			4'hA: segments = 7'b0001000;  // upper case A
			4'hB: segments = 7'b0000011;  // lower case b
			4'hC: segments = 7'b1000110;
			4'hD: segments = 7'b0100001;  // lower case d
			4'hE: segments = 7'b0000110;
			4'hF: segments = 7'b0001110;
			default: segments = 7'b1111111;  // blank
		endcase
	end

endmodule

/* design/memory_game_top.sv */
// Memory game top level
module memory_game_top
(
	input  logic                       clock,
	input  logic                       reset_n,
	input  logic                       go_n,          // push button
	input  memory_game_pkg::card_set_t cards,         // switches
	output logic                       first_phase,
	output logic                       second_phase,
	output logic                       judge_phase,
	output logic                       match,
	output memory_game_pkg::player_t   turn,
	output memory_game_pkg::segments_t hex_p1,
	output memory_game_pkg::segments_t hex_p2,
	output memory_game_pkg::segments_t hex_sec_ones,
	output memory_game_pkg::segments_t hex_sec_tens
);

	logic pick_first;
	logic pick_second;
	logic judge_now;
	memory_game_pkg::bcd_digit_t score_p1;
	memory_game_pkg::bcd_digit_t score_p2;
	memory_game_pkg::bcd_digit_t sec_ones;
	memory_game_pkg::bcd_digit_t sec_tens;

	turn_control u_turn_control (
		.clock        (clock),
		.reset_n      (reset_n),
		.go_n         (go_n),
		.first_phase  (first_phase),
		.second_phase (second_phase),
		.judge_phase  (judge_phase),
		.pick_first   (pick_first),
		.pick_second  (pick_second),
		.judge_now    (judge_now)
	);

	pair_checker u_pair_checker (
		.clock       (clock),
		.reset_n     (reset_n),
		.cards       (cards),
		.pick_first  (pick_first),
		.pick_second (pick_second),
		.judge_now   (judge_now),
		.match       (match),
		.turn        (turn)
	);

	score_keeper u_score_keeper (
		.clock    (clock),
		.reset_n  (reset_n),
		.match    (match),
		.turn     (turn),
		.score_p1 (score_p1),
		.score_p2 (score_p2)
	);

	// free running, not tied to the game
	round_timer u_round_timer (
		.clock    (clock),
		.reset_n  (reset_n),
		.sec_ones (sec_ones),
		.sec_tens (sec_tens)
	);

	seven_seg_decoder u_hex_p1       (.digit(score_p1), .segments(hex_p1));
	seven_seg_decoder u_hex_p2       (.digit(score_p2), .segments(hex_p2));
	seven_seg_decoder u_hex_sec_ones (.digit(sec_ones), .segments(hex_sec_ones));
	seven_seg_decoder u_hex_sec_tens (.digit(sec_tens), .segments(hex_sec_tens));

endmodule

/* tests/memory_game_properties.sv */
// Memory game checker
`include "memory_game_defines.svh"

module memory_game_properties
(
	input logic                        clock,
	input logic                        reset_n,
	input logic                        go_n,
	input memory_game_pkg::card_set_t  cards,
	input logic                        first_phase,
	input logic                        second_phase,
	input logic                        judge_phase,
	input logic                        match,
	input memory_game_pkg::player_t    turn,
	input memory_game_pkg::bcd_digit_t score_p1,
	input memory_game_pkg::bcd_digit_t score_p2,
	input memory_game_pkg::bcd_digit_t sec_ones,
	input memory_game_pkg::bcd_digit_t sec_tens,
	input memory_game_pkg::segments_t  hex_p1,
	input memory_game_pkg::segments_t  hex_p2,
	input memory_game_pkg::segments_t  hex_sec_ones,
	input memory_game_pkg::segments_t  hex_sec_tens
);
	timeunit 1ns;
	timeprecision 1ps;

	int assert_failures = 0;             // read by the testbench
	logic held;                          // press seen in this phase
	logic reset_d;
	logic release_now;
	logic judge_rel;
	logic both_picked;
	logic pair_seen;                     // shadowed picks form a table pair
	logic changed;
	logic [2:0] any_d;                   // judge release pipeline
	logic [2:0] hit_d;
	logic [2:0] miss_d;
	logic saved_turn;
	logic [3:0] saved_p1;
	logic [3:0] saved_p2;
	logic [7:0] last_digits;
	logic [31:0] since;                  // cycles since last timer step
	memory_game_pkg::card_set_t shadow_first;
	memory_game_pkg::card_set_t shadow_second;

	// own copy of the pair table
	function automatic logic table_pair(logic [`MG_NUM_CARDS-1:0] a,
		logic [`MG_NUM_CARDS-1:0] b);
		int hi [9] = '{17, 16, 15, 14, 13, 12, 9, 8, 6};
		int lo [9] = '{10, 0, 4, 3, 2, 11, 7, 5, 1};
		logic r;
		r = 1'b0;
		for (int i = 0; i < 9; i++)
			r |= (a[hi[i]] & b[lo[i]]) | (a[lo[i]] & b[hi[i]]);
		return r;
	endfunction

	function automatic logic [3:0] inc_mod10(logic [3:0] v);
		return (v == 4'd9) ? 4'd0 : v + 4'd1;
	endfunction

	// bcd countdown that reloads after 00
	function automatic logic [7:0] bcd_down(logic [7:0] v);
		if (v[3:0] != 4'd0)
			return {v[7:4], v[3:0] - 4'd1};
		if (v[7:4] != 4'd0)
			return {v[7:4] - 4'd1, 4'd9};
		return {4'(`MG_TIMER_START_TENS), 4'(`MG_TIMER_START_ONES)};
	endfunction

	// active-low gfedcba pattern of a decimal digit
	function automatic logic [6:0] seg_pattern(logic [3:0] d);
		case (d)
			4'd0: return 7'h40;
			4'd1: return 7'h79;
			4'd2: return 7'h24;
			4'd3: return 7'h30;
			4'd4: return 7'h19;
			4'd5: return 7'h12;
			4'd6: return 7'h02;
			4'd7: return 7'h78;
			4'd8: return 7'h00;
			4'd9: return 7'h18;
			default: return 7'h7f;           // not a decimal digit
		endcase
	endfunction

	assign release_now = held && go_n;
	assign judge_rel   = release_now && judge_phase;
	assign both_picked = (shadow_first != '0) && (shadow_second != '0);
	assign pair_seen   = table_pair(shadow_first, shadow_second);
	assign changed     = {sec_tens, sec_ones} != last_digits;

	always_ff @(posedge clock)
		reset_d <= reset_n;

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			held          <= 1'b0;
			shadow_first  <= '0;
			shadow_second <= '0;
			any_d         <= '0;
			hit_d         <= '0;
			miss_d        <= '0;
			last_digits   <= {sec_tens, sec_ones};
			since         <= '0;
		end
		else
		begin
			held <= release_now ? 1'b0 : (held | !go_n);
			if (release_now && first_phase)
				shadow_first <= cards;   // card set at the release
			if (release_now && second_phase)
				shadow_second <= cards;
			any_d  <= {any_d[1:0], judge_rel};
			hit_d  <= {hit_d[1:0], judge_rel && both_picked && pair_seen};
			miss_d <= {miss_d[1:0], judge_rel && both_picked && !pair_seen};
			if (judge_rel)
			begin
				saved_turn <= turn;
				saved_p1   <= score_p1;
				saved_p2   <= score_p2;
			end
			last_digits <= {sec_tens, sec_ones};
			since       <= changed ? 32'd1 : since + 32'd1;
		end
	end

	reset_values: assert property (@(posedge clock) (reset_n && !reset_d) |->
		first_phase && !match && turn == 1'b0 && hex_p1 == 7'h40 && hex_p2 == 7'h40
		&& hex_sec_tens == 7'h02 && hex_sec_ones == 7'h40)
		else
		begin
			assert_failures++;
			$error("FAILED reset values, turn 0x%h hex_p1 0x%h", turn, hex_p1);
		end

	phase_onehot: assert property (@(posedge clock) disable iff (!reset_n)
		$onehot({first_phase, second_phase, judge_phase}))
		else
		begin
			assert_failures++;
			$error("FAILED phase lights 0x%h", {first_phase, second_phase, judge_phase});
		end

	first_to_second: assert property (@(posedge clock) disable iff (!reset_n)
		release_now && first_phase |=> second_phase)
		else
		begin
			assert_failures++;
			$error("FAILED second_phase 0x%h expected 0x1", second_phase);
		end

	second_to_judge: assert property (@(posedge clock) disable iff (!reset_n)
		release_now && second_phase |=> judge_phase)
		else
		begin
			assert_failures++;
			$error("FAILED judge_phase 0x%h expected 0x1", judge_phase);
		end

	judge_to_first: assert property (@(posedge clock) disable iff (!reset_n)
		release_now && judge_phase |=> first_phase)
		else
		begin
			assert_failures++;
			$error("FAILED first_phase 0x%h expected 0x1", first_phase);
		end

	phase_hold: assert property (@(posedge clock) disable iff (!reset_n)
		!release_now |=> $stable({first_phase, second_phase, judge_phase}))
		else
		begin
			assert_failures++;
			$error("phase lights moved without a button release");
		end

	verdict: assert property (@(posedge clock) disable iff (!reset_n)
		any_d[1] |-> match == hit_d[1] && turn == (miss_d[1] ? ~saved_turn : saved_turn))
		else
		begin
			assert_failures++;
			$error("FAILED turn 0x%h match 0x%h after judge", turn, match);
		end

	match_only_on_hit: assert property (@(posedge clock) disable iff (!reset_n)
		match |-> hit_d[1])
		else
		begin
			assert_failures++;
			$error("match pulsed without a judged pair");
		end

	score_update: assert property (@(posedge clock) disable iff (!reset_n)
		any_d[2] |-> !match
		&& score_p1 == ((hit_d[2] && !saved_turn) ? inc_mod10(saved_p1) : saved_p1)
		&& score_p2 == ((hit_d[2] && saved_turn) ? inc_mod10(saved_p2) : saved_p2))
		else
		begin
			assert_failures++;
			$error("FAILED score_p1 0x%h score_p2 0x%h", score_p1, score_p2);
		end

	// every display follows its digit, scores and timer alike
	display_decode: assert property (@(posedge clock) disable iff (!reset_n)
		hex_p1 == seg_pattern(score_p1) && hex_p2 == seg_pattern(score_p2)
		&& hex_sec_ones == seg_pattern(sec_ones) && hex_sec_tens == seg_pattern(sec_tens))
		else
		begin
			assert_failures++;
			$error("FAILED hex_p1 0x%h hex_p2 0x%h hex_sec_tens 0x%h hex_sec_ones 0x%h",
				hex_p1, hex_p2, hex_sec_tens, hex_sec_ones);
		end

	timer_step: assert property (@(posedge clock) disable iff (!reset_n)
		changed |-> since == `MG_TICKS_PER_SECOND
		&& {sec_tens, sec_ones} == bcd_down(last_digits))
		else
		begin
			assert_failures++;
			$error("FAILED timer 0x%h after 0x%h", {sec_tens, sec_ones}, last_digits);
		end

endmodule

bind memory_game_top memory_game_properties u_properties (.*);

/* tests/memory_game_tb.sv */
// Memory game testbench
`include "memory_game_defines.svh"

module memory_game_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic clock = 1'b0;
	logic reset_n;
	logic go_n;
	logic [`MG_NUM_CARDS-1:0] cards;
	logic first_phase;
	logic second_phase;
	logic judge_phase;
	logic match;
	logic turn;
	logic [6:0] hex_p1;
	logic [6:0] hex_p2;
	logic [6:0] hex_sec_ones;
	logic [6:0] hex_sec_tens;
	int errors = 0;                      // timeouts
	int seed = 88009;

	memory_game_top UUT (.*);

	always #20 clock = ~clock;           // 40 ns period

	// table partner, used to steer random turns toward hits
	function automatic int partner_of(int idx);
		case (idx)
			17: return 10;
			10: return 17;
			16: return 0;
			0:  return 16;
			15: return 4;
			4:  return 15;
			14: return 3;
			3:  return 14;
			13: return 2;
			2:  return 13;
			12: return 11;
			11: return 12;
			9:  return 7;
			7:  return 9;
			8:  return 5;
			5:  return 8;
			6:  return 1;
			default: return 6;
		endcase
	endfunction

	task automatic press_button();
		@(posedge clock) go_n <= 1'b0;
		repeat (2) @(posedge clock);     // stays in the hold state
	endtask

	// release, then wait for the phase light to move on
	task automatic release_button();
		logic [2:0] old_phase;
		int n;
		old_phase = {first_phase, second_phase, judge_phase};
		go_n <= 1'b1;
		for (n = 0; n < 8; n++)
		begin
			@(posedge clock);
			#1;
			if ({first_phase, second_phase, judge_phase} != old_phase)
				break;
		end
		if (n == 8)
		begin
			errors++;
			$display("timeout: phase lights did not advance after a button release");
		end
		@(posedge clock);
	endtask

	task automatic play_turn(input logic [`MG_NUM_CARDS-1:0] a, input logic [`MG_NUM_CARDS-1:0] b);
		cards <= a;
		press_button();
		release_button();
		cards <= b;                      // first set already captured
		press_button();
		release_button();
		press_button();
		release_button();                // judge
		repeat (3) @(posedge clock);
	endtask

	// lets the countdown run through 00 and back to 60
	task automatic run_timer_wrap();
		int n;
		logic seen_zero;
		seen_zero = 1'b0;
		for (n = 0; n < 62 * `MG_TICKS_PER_SECOND + 8; n++)
		begin
			@(posedge clock);
			if (UUT.sec_tens == 4'd0 && UUT.sec_ones == 4'd0)
				seen_zero = 1'b1;
			if (seen_zero && UUT.sec_tens == 4'd6)
				break;
		end
		if (n == 62 * `MG_TICKS_PER_SECOND + 8)
		begin
			errors++;
			$display("timeout: round timer never wrapped back to 60");
		end
	endtask

	initial
	begin
		int a;
		int b;
		reset_n = 1'b0;
		go_n    = 1'b1;
		cards   = '0;
		repeat (10) @(posedge clock);
		reset_n <= 1'b1;
		repeat (2) @(posedge clock);
		play_turn(18'h1 << 17, 18'h1 << 10);   // pair
		play_turn(18'h1 << 0, 18'h1 << 1);     // mismatch
		play_turn('0, 18'h1 << 3);             // empty first pick
		for (int i = 0; i < 11; i++)
			play_turn(18'h1 << 9, 18'h1 << 7);   // score wraps past 9
		for (int i = 0; i < 60; i++)
		begin
			a = {$random(seed)} % 18;
			if ({$random(seed)} % 3 == 0)
				b = partner_of(a);
			else
				b = {$random(seed)} % 18;
			play_turn(18'h1 << a, 18'h1 << b);
		end
		if (`MG_TICKS_PER_SECOND <= 64)
			run_timer_wrap();
		$display("errors: %0d timeouts, %0d assertion failures",
			errors, UUT.u_properties.assert_failures);
		if (errors == 0 && UUT.u_properties.assert_failures == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* files.f */
+incdir+design
design/memory_game_pkg.sv
design/turn_control.sv
design/pair_checker.sv
design/score_keeper.sv
design/round_timer.sv
design/seven_seg_decoder.sv
design/memory_game_top.sv
tests/memory_game_properties.sv
tests/memory_game_tb.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal +define+MG_TICKS_PER_SECOND=4 \
	--top-module memory_game_tb -f files.f -o memory_game_sim \
	&& ./obj_dir/memory_game_sim > sim.log 2>&1 ; cat sim.log ; \
	grep -q "ALL TESTS PASSED" sim.log && ! grep -q "SOME TESTS FAILED" sim.log || exit 1
